// ==== ciu_l2regs.f ====
+incdir+include
verilog/ciu_l2regs_pkg.sv
verilog/ciu_req_arbiter.sv
verilog/ciu_access_ctrl.sv
verilog/ciu_shared_csr.sv
verilog/ciu_l2regs_top.sv
testbench/ciu_l2regs_sva.sv
testbench/ciu_l2regs_tb.sv

// ==== include/ciu_l2regs_cfg.svh ====
// Port count, data width, register map and reset values, included by the package and RTL
`ifndef CIU_L2REGS_CFG_SVH
`define CIU_L2REGS_CFG_SVH

// Requesting cores
`define CIU_N_REQ       4

// Register word width
`define CIU_DATA_W      64

// Shared register indices
`define CIU_IDX_CCR2    4'h0
`define CIU_IDX_CHR2    4'h1

// Op field bit positions
`define CIU_OP_CSRRC    0
`define CIU_OP_CSRRS    1
`define CIU_OP_CSRRW    2
`define CIU_OP_WT       3

// Register index sits above the op bits
`define CIU_OP_IDX_LSB  4

// Tag and data RAM latency after reset
`define CIU_LTNCY_RST   3'd1

// Implemented CHR2 bits
`define CIU_CHR2_W      11

`endif

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module ciu_l2regs_tb -f ciu_l2regs.f -o sim \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim +verilator+error+limit+100 > sim.log 2>&1 || echo "simulator returned an error"
grep -qxF '*** PASSED ***' sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

// ==== testbench/ciu_l2regs_sva.sv ====
// Protocol checks for the shared L2 register block, bound into the top level
`timescale 1ns/1ps

module ciu_l2regs_sva (
  input logic                     ccr2_clk,
  input logic                     cpurst_b,
  input ciu_l2regs_pkg::req_vec_t sel,
  input ciu_l2regs_pkg::req_vec_t cmplt,
  input logic                     rst_req
);

  int fail_cnt = 0;

  //============================================================
  // Completion handshake
  //============================================================
  cmplt_onehot: assert property (@(posedge ccr2_clk) disable iff (!cpurst_b)
    $onehot0(cmplt))
  else
  begin
    fail_cnt++;
    $error("more than one completion bit high");
  end

  // Requester drops sel in the middle of its completion cycle
  cmplt_selected: assert property (@(posedge ccr2_clk) disable iff (!cpurst_b)
    (cmplt & ~$past(sel)) == '0)
  else
  begin
    fail_cnt++;
    $error("completion for a port that was not selected");
  end

  cmplt_single: assert property (@(posedge ccr2_clk) disable iff (!cpurst_b)
    |cmplt |=> cmplt == '0)
  else
  begin
    fail_cnt++;
    $error("completion held for more than one cycle");
  end

  // Reset request only in the cycle right after release
  rst_req_pulse: assert property (@(posedge ccr2_clk) disable iff (!cpurst_b)
    rst_req == !$past(cpurst_b))
  else
  begin
    fail_cnt++;
    $error("rst_req outside the first cycle after reset");
  end

endmodule

bind ciu_l2regs_top ciu_l2regs_sva u_sva (
  .ccr2_clk (ccr2_clk),
  .cpurst_b (cpurst_b),
  .sel      (sel),
  .cmplt    (cmplt),
  .rst_req  (rst_req)
);

// ==== testbench/ciu_l2regs_tb.sv ====
// Testbench for the shared L2 register block, run as the simulation top with a shadow model
`timescale 1ns/1ps
`include "ciu_l2regs_cfg.svh"

module ciu_l2regs_tb;

  import ciu_l2regs_pkg::*;

  localparam int K_RD = 0;
  localparam int K_RW = 1;
  localparam int K_RS = 2;
  localparam int K_RC = 3;
  localparam int MAX_CYCLES = 2000;
  localparam csr_data_t CCR2_MASK  = 64'h0000_0000_E3CF_0000;
  localparam csr_data_t CCR2_CONST = 64'h0000_0000_0000_0009;
  localparam csr_data_t CCR2_RST   = 64'h0000_0000_0041_0000;
  localparam csr_data_t CHR2_MASK  = 64'h0000_0000_0000_07FF;

  logic          ccr2_clk;
  logic          cpurst_b;
  req_vec_t      sel;
  regs_req_arr_t req;
  req_vec_t      cmplt;
  csr_data_t     rdata;
  l2c_ram_cfg_t  ram_cfg;
  ciu_hint_t     hint;
  logic          rst_req;

  csr_data_t shadow_ccr2;
  csr_data_t shadow_chr2;
  int        err_cnt = 0;
  int        cycle_cnt = 0;
  int        done_order[$];

  ciu_l2regs_top uut (
    .ccr2_clk (ccr2_clk),
    .cpurst_b (cpurst_b),
    .sel      (sel),
    .req      (req),
    .cmplt    (cmplt),
    .rdata    (rdata),
    .ram_cfg  (ram_cfg),
    .hint     (hint),
    .rst_req  (rst_req)
  );

  initial
  begin
    ccr2_clk = 1'b0;
    forever #4 ccr2_clk = ~ccr2_clk;
  end

  initial
  begin
    while (cycle_cnt < MAX_CYCLES)
    begin
      @(posedge ccr2_clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  //============================================================
  // Shadow register model
  //============================================================
  function automatic csr_data_t shadow_view(input reg_idx_t idx);
    csr_data_t v;
    v = '0;
    if (idx == `CIU_IDX_CCR2)
      v = shadow_ccr2 | CCR2_CONST;
    else if (idx == `CIU_IDX_CHR2)
      v = shadow_chr2;
    return v;
  endfunction

  function automatic csr_data_t merge_op(input int kind, input csr_data_t old,
                                         input csr_data_t wd);
    if (kind == K_RW)
      return wd;
    else if (kind == K_RS)
      return old | wd;
    return old & ~wd;
  endfunction

  function automatic void apply_write(input reg_idx_t idx, input csr_data_t val);
    if (idx == `CIU_IDX_CCR2)
      shadow_ccr2 = val & CCR2_MASK;
    else if (idx == `CIU_IDX_CHR2)
      shadow_chr2 = val & CHR2_MASK;
  endfunction

  // CCR2 fields packed in struct order
  function automatic csr_data_t exp_ram_cfg();
    return {53'b0, shadow_ccr2[31], shadow_ccr2[30:29], shadow_ccr2[25],
            shadow_ccr2[24:22], shadow_ccr2[19], shadow_ccr2[18:16]};
  endfunction

  function automatic csr_data_t rand_word();
    return {$urandom, $urandom};
  endfunction

  task automatic check_val(input string what, input csr_data_t got, input csr_data_t exp);
    assert (got === exp)
    else
    begin
      err_cnt++;
      $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_outputs();
    check_val("ram_cfg", {53'b0, ram_cfg}, exp_ram_cfg());
    check_val("hint", {53'b0, hint}, shadow_chr2);
  endtask

  //============================================================
  // One access on one port, checked at its completion
  //============================================================
  task automatic run_access(input int port, input reg_idx_t idx, input int kind,
                            input csr_data_t wd);
    logic [7:0] op_bits;
    csr_data_t  old_val;
    logic       seen;
    op_bits = '0;
    op_bits[`CIU_OP_IDX_LSB +: 4] = idx;
    op_bits[`CIU_OP_WT]    = (kind != K_RD);
    op_bits[`CIU_OP_CSRRW] = (kind == K_RW);
    op_bits[`CIU_OP_CSRRS] = (kind == K_RS);
    op_bits[`CIU_OP_CSRRC] = (kind == K_RC);
    seen = 1'b0;
    @(negedge ccr2_clk);
    req[port].op    = regs_op_t'(op_bits);
    req[port].wdata = wd;
    sel[port]       = 1'b1;
    while (!seen)
    begin
      @(negedge ccr2_clk);
      seen = cmplt[port];
    end
    sel[port] = 1'b0;
    old_val = shadow_view(idx);
    check_val("rdata", rdata, old_val);
    if (kind != K_RD)
      apply_write(idx, merge_op(kind, old_val, wd));
    check_outputs();
    done_order.push_back(port);
  endtask

  initial
  begin
    csr_data_t w_rs;
    csr_data_t w_rc;
    int        total;
    cpurst_b = 1'b0;
    sel      = '0;
    req      = '0;
    void'($urandom(73266));
    shadow_ccr2 = CCR2_RST;
    shadow_chr2 = '0;
    repeat (10) @(negedge ccr2_clk);
    check_val("rst_req in reset", {63'b0, rst_req}, 64'd1);
    cpurst_b = 1'b1;
    @(negedge ccr2_clk);
    check_val("rst_req after release", {63'b0, rst_req}, 64'd0);
    check_outputs();

    // Reset values
    run_access(0, `CIU_IDX_CCR2, K_RD, '0);
    run_access(1, `CIU_IDX_CHR2, K_RD, '0);

    // Swap with random data and read back
    for (int i = 0; i < 4; i++)
    begin
      run_access(2, `CIU_IDX_CCR2, K_RW, rand_word());
      run_access(0, `CIU_IDX_CCR2, K_RD, '0);
      run_access(3, `CIU_IDX_CHR2, K_RW, rand_word());
      run_access(1, `CIU_IDX_CHR2, K_RD, '0);
    end

    // Set and clear bits
    for (int i = 0; i < 6; i++)
      run_access(i % 4, `CIU_IDX_CHR2, (i % 2 == 0) ? K_RS : K_RC, rand_word());
    run_access(1, `CIU_IDX_CCR2, K_RS, rand_word());
    run_access(2, `CIU_IDX_CCR2, K_RC, rand_word());

    // All ports at once, highest port first
    w_rs = rand_word();
    w_rc = rand_word();
    done_order.delete();
    fork
      run_access(0, `CIU_IDX_CCR2, K_RD, '0);
      run_access(1, `CIU_IDX_CHR2, K_RC, w_rc);
      run_access(2, `CIU_IDX_CHR2, K_RD, '0);
      run_access(3, `CIU_IDX_CHR2, K_RS, w_rs);
    join
    for (int k = 0; k < 4; k++)
      check_val("completion order", csr_data_t'(done_order[k]), csr_data_t'(3 - k));

    // Unmapped index
    run_access(2, 4'd5, K_RD, '0);
    run_access(1, 4'd5, K_RW, rand_word());
    run_access(0, `CIU_IDX_CCR2, K_RD, '0);
    run_access(3, `CIU_IDX_CHR2, K_RD, '0);

    total = err_cnt + uut.u_sva.fail_cnt;
    $display("Errors: %0d value checks, %0d protocol assertions", err_cnt,
             uut.u_sva.fail_cnt);
    if (total == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== verilog/ciu_access_ctrl.sv ====
// Access sequencer: steps read or read-then-write, merges the CSR op and signals completion
`timescale 1ns/1ps
`include "ciu_l2regs_cfg.svh"

module ciu_access_ctrl (
  input  logic                        ccr2_clk,
  input  logic                        cpurst_b,
  input  logic                        active,
  input  ciu_l2regs_pkg::req_vec_t    grant,
  input  ciu_l2regs_pkg::regs_req_t   cur_req,
  input  ciu_l2regs_pkg::csr_data_t   rd_view,
  output ciu_l2regs_pkg::regs_state_e state,
  output ciu_l2regs_pkg::req_vec_t    cmplt,
  output ciu_l2regs_pkg::csr_data_t   rdata,
  output logic                        wr_en,
  output ciu_l2regs_pkg::reg_idx_t    wr_idx,
  output ciu_l2regs_pkg::csr_data_t   wdata_final
);

  import ciu_l2regs_pkg::*;

  logic [7:0]  op_vec;
  logic        is_wt;
  logic        done;
  regs_state_e next_state;

  // Raw op bits of the granted request
  assign op_vec = cur_req.op;
  assign is_wt  = op_vec[`CIU_OP_WT];
  assign wr_idx = op_vec[`CIU_OP_IDX_LSB +: 4];

  //============================================================
  // State machine
  //============================================================
  always_ff @(posedge ccr2_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state <= IDLE;
    else
      state <= next_state;
  end

  always_comb
  begin
    case (state)
      IDLE:    next_state = active ? READ : IDLE;
      READ:    next_state = is_wt ? WRITE : IDLE;
      WRITE:   next_state = IDLE;
      default: next_state = IDLE;
    endcase
  end

  // Old register value, captured when the request is accepted
  always_ff @(posedge ccr2_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      rdata <= '0;
    else if (state == IDLE && active)
      rdata <= rd_view;
  end

  //============================================================
  // Write value and completion
  //============================================================
  assign wdata_final =
    ({`CIU_DATA_W{op_vec[`CIU_OP_CSRRW]}} & cur_req.wdata) |
    ({`CIU_DATA_W{op_vec[`CIU_OP_CSRRS]}} & (rdata | cur_req.wdata)) |
    ({`CIU_DATA_W{op_vec[`CIU_OP_CSRRC]}} & (rdata & ~cur_req.wdata));

  // Register updates at the edge that leaves READ
  assign wr_en = (state == READ) && is_wt;

  // Reads finish in READ, writes one cycle later
  assign done  = is_wt ? (state == WRITE) : (state == READ);
  assign cmplt = {`CIU_N_REQ{done}} & grant;

endmodule

// ==== verilog/ciu_l2regs_pkg.sv ====
// Shared types of the L2 register block, imported by every RTL module of the project
`include "ciu_l2regs_cfg.svh"

package ciu_l2regs_pkg;

  typedef logic [`CIU_DATA_W-1:0] csr_data_t;
  typedef logic [3:0]             reg_idx_t;
  typedef logic [`CIU_N_REQ-1:0]  req_vec_t;
  typedef logic [2:0]             ram_ltncy_t;

  // Op bits as sent by a core, idx in the upper nibble
  typedef struct packed {
    reg_idx_t idx;
    logic     wt;
    logic     csrrw;
    logic     csrrs;
    logic     csrrc;
  } regs_op_t;

  typedef struct packed {
    regs_op_t  op;
    csr_data_t wdata;
  } regs_req_t;

  typedef regs_req_t [`CIU_N_REQ-1:0] regs_req_arr_t;

  // CCR2 fields seen by the L2 RAMs and prefetchers
  typedef struct packed {
    logic       tprf;
    logic [1:0] iprf;
    logic       tsetup;
    ram_ltncy_t tag_ltncy;
    logic       dsetup;
    ram_ltncy_t data_ltncy;
  } l2c_ram_cfg_t;

  // CHR2 bit 10 down to bit 0
  typedef struct packed {
    logic       so_ostd_dis;
    logic       global_icg_en;
    logic       sysio_icg_en;
    logic       apbif_icg_en;
    logic       l2c_icg_en;
    logic       dvm_dis;
    logic       sf_dis;
    logic [1:0] rsvd;
    logic       icg_en;
    logic       bar_dis;
  } ciu_hint_t;

  typedef enum logic [1:0] {
    IDLE  = 2'b00,
    READ  = 2'b01,
    WRITE = 2'b10
  } regs_state_e;

endpackage

// ==== verilog/ciu_l2regs_top.sv ====
// Top of the shared L2 register block: arbiter, access sequencer, CSR storage, reset request
`timescale 1ns/1ps

module ciu_l2regs_top (
  input  logic                          ccr2_clk,
  input  logic                          cpurst_b,
  input  ciu_l2regs_pkg::req_vec_t      sel,
  input  ciu_l2regs_pkg::regs_req_arr_t req,
  output ciu_l2regs_pkg::req_vec_t      cmplt,
  output ciu_l2regs_pkg::csr_data_t     rdata,
  output ciu_l2regs_pkg::l2c_ram_cfg_t  ram_cfg,
  output ciu_l2regs_pkg::ciu_hint_t     hint,
  output logic                          rst_req
);

  import ciu_l2regs_pkg::*;

  req_vec_t    grant;
  logic        active;
  regs_req_t   cur_req;
  regs_state_e state;
  logic        wr_en;
  reg_idx_t    wr_idx;
  csr_data_t   wdata_final;
  csr_data_t   rd_view;

  ciu_req_arbiter u_arbiter (
    .ccr2_clk (ccr2_clk),
    .cpurst_b (cpurst_b),
    .sel      (sel),
    .req      (req),
    .state    (state),
    .grant    (grant),
    .active   (active),
    .cur_req  (cur_req)
  );

  ciu_access_ctrl u_access_ctrl (
    .ccr2_clk    (ccr2_clk),
    .cpurst_b    (cpurst_b),
    .active      (active),
    .grant       (grant),
    .cur_req     (cur_req),
    .rd_view     (rd_view),
    .state       (state),
    .cmplt       (cmplt),
    .rdata       (rdata),
    .wr_en       (wr_en),
    .wr_idx      (wr_idx),
    .wdata_final (wdata_final)
  );

  ciu_shared_csr u_shared_csr (
    .ccr2_clk    (ccr2_clk),
    .cpurst_b    (cpurst_b),
    .wr_en       (wr_en),
    .wr_idx      (wr_idx),
    .wdata_final (wdata_final),
    .rd_idx      (cur_req.op.idx),
    .rd_view     (rd_view),
    .ram_cfg     (ram_cfg),
    .hint        (hint)
  );

  //============================================================
  // L2 reset request, one cycle after reset release
  //============================================================
  always_ff @(posedge ccr2_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      rst_req <= 1'b1;
    else
      rst_req <= 1'b0;
  end

endmodule

// ==== verilog/ciu_req_arbiter.sv ====
// Fixed-priority arbiter for the core register ports, holds the grant while an access runs
`timescale 1ns/1ps
`include "ciu_l2regs_cfg.svh"

module ciu_req_arbiter (
  input  logic                          ccr2_clk,
  input  logic                          cpurst_b,
  input  ciu_l2regs_pkg::req_vec_t      sel,
  input  ciu_l2regs_pkg::regs_req_arr_t req,
  input  ciu_l2regs_pkg::regs_state_e   state,
  output ciu_l2regs_pkg::req_vec_t      grant,
  output logic                          active,
  output ciu_l2regs_pkg::regs_req_t     cur_req
);

  import ciu_l2regs_pkg::*;

  req_vec_t pick;
  req_vec_t grant_q;

  //============================================================
  // Priority pick, highest port number wins
  //============================================================
  always_comb
  begin
    pick = '0;
    for (int p = 0; p < `CIU_N_REQ; p++)
    begin
      if (sel[p])
      begin
        pick    = '0;
        pick[p] = 1'b1;
      end
    end
  end

  // Grant stays with the accepted port until back in IDLE
  always_ff @(posedge ccr2_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      grant_q <= '0;
    else if (state == IDLE && |pick)
      grant_q <= pick;
  end

  assign grant  = (state == IDLE) ? pick : grant_q;
  assign active = |grant;

  //============================================================
  // Request mux
  //============================================================
  always_comb
  begin
    cur_req = '0;
    for (int p = 0; p < `CIU_N_REQ; p++)
    begin
      if (grant[p])
        cur_req = req[p];
    end
  end

endmodule

// ==== verilog/ciu_shared_csr.sv ====
// Storage for the shared CCR2 and CHR2 registers, with the read view and L2 field outputs
`timescale 1ns/1ps
`include "ciu_l2regs_cfg.svh"

module ciu_shared_csr (
  input  logic                         ccr2_clk,
  input  logic                         cpurst_b,
  input  logic                         wr_en,
  input  ciu_l2regs_pkg::reg_idx_t     wr_idx,
  input  ciu_l2regs_pkg::csr_data_t    wdata_final,
  input  ciu_l2regs_pkg::reg_idx_t     rd_idx,
  output ciu_l2regs_pkg::csr_data_t    rd_view,
  output ciu_l2regs_pkg::l2c_ram_cfg_t ram_cfg,
  output ciu_l2regs_pkg::ciu_hint_t    hint
);

  import ciu_l2regs_pkg::*;

  logic         ccr2_wen;
  logic         chr2_wen;
  l2c_ram_cfg_t ccr2_q;
  ciu_hint_t    chr2_q;
  csr_data_t    ccr2_view;
  csr_data_t    chr2_view;

  assign ccr2_wen = wr_en && (wr_idx == `CIU_IDX_CCR2);
  assign chr2_wen = wr_en && (wr_idx == `CIU_IDX_CHR2);

  //============================================================
  // CCR2
  //============================================================
  always_ff @(posedge ccr2_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      ccr2_q            <= '0;
      ccr2_q.tag_ltncy  <= `CIU_LTNCY_RST;
      ccr2_q.data_ltncy <= `CIU_LTNCY_RST;
    end
    else if (ccr2_wen)
    begin
      ccr2_q.tprf       <= wdata_final[31];
      ccr2_q.iprf       <= wdata_final[30:29];
      ccr2_q.tsetup     <= wdata_final[25];
      ccr2_q.tag_ltncy  <= wdata_final[24:22];
      ccr2_q.dsetup     <= wdata_final[19];
      ccr2_q.data_ltncy <= wdata_final[18:16];
    end
  end

  // Bit 0 inclusive and bit 3 L2 enable are tied high
  always_comb
  begin
    ccr2_view        = '0;
    ccr2_view[31]    = ccr2_q.tprf;
    ccr2_view[30:29] = ccr2_q.iprf;
    ccr2_view[25]    = ccr2_q.tsetup;
    ccr2_view[24:22] = ccr2_q.tag_ltncy;
    ccr2_view[19]    = ccr2_q.dsetup;
    ccr2_view[18:16] = ccr2_q.data_ltncy;
    ccr2_view[3]     = 1'b1;
    ccr2_view[0]     = 1'b1;
  end

  //============================================================
  // CHR2
  //============================================================
  always_ff @(posedge ccr2_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      chr2_q <= '0;
    else if (chr2_wen)
      chr2_q <= ciu_hint_t'(wdata_final[`CIU_CHR2_W-1:0]);
  end

  always_comb
  begin
    chr2_view                   = '0;
    chr2_view[`CIU_CHR2_W-1:0] = chr2_q;
  end

  // Unmapped indices read as zero
  always_comb
  begin
    case (rd_idx)
      `CIU_IDX_CCR2: rd_view = ccr2_view;
      `CIU_IDX_CHR2: rd_view = chr2_view;
      default:       rd_view = '0;
    endcase
  end

  assign ram_cfg = ccr2_q;
  assign hint    = chr2_q;

endmodule
